// ==== logic/logistic_map_cfg.svh ====
`ifndef LOGISTIC_MAP_CFG_SVH
`define LOGISTIC_MAP_CFG_SVH

//////////////////////////////////////////////////
// fixed point formats
//////////////////////////////////////////////////

// iterate, unsigned Q1.31
`define LM_FRAC_BITS 31
`define LM_ONE 32'h8000_0000    // 1.0
// growth rate r, unsigned Q2.30
`define LM_R_FRAC 30
`define LM_R_CODE 32'hE51E_B852 // 3.58, rounded
`define LM_SEED 32'h4000_0000   // 0.5 after reset

//////////////////////////////////////////////////
// led output
//////////////////////////////////////////////////

`define LM_DUTY_BITS 8          // duty and pwm phase width
`define LM_DUTY_SHIFT 23        // top fraction bits of x become the duty
`define LM_UPDATE_PERIOD 64     // cycles between target samples

`endif

// ==== logic/logistic_map_pkg.sv ====
`include "logistic_map_cfg.svh"

//////////////////////////////////////////////////
// shared types for the logistic map datapath
//////////////////////////////////////////////////

package logistic_map_pkg;

   // iterates and products, unsigned Q1.31
   // x stays in [0, 1], so bit 31 is only ever set for exactly 1.0
   typedef logic [31:0] fxp_t;

   // pwm duty, taken from the top fraction bits of x
   typedef logic [`LM_DUTY_BITS-1:0] duty_t;

endpackage

// ==== logic/iterate_sequencer.sv ====
`timescale 1ns/100ps
`include "logistic_map_cfg.svh"

// keeps the current iterate and feeds it around the product/scale loop
module iterate_sequencer (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   load,        // restart from seed
   input  logistic_map_pkg::fxp_t seed,
   input  logic                   res_valid,
   input  logistic_map_pkg::fxp_t res_x,
   input  logic                   issue_ready,
   output logic                   issue_valid,
   output logistic_map_pkg::fxp_t issue_x,
   output logic                   res_ready,
   output logistic_map_pkg::fxp_t x,
   output logic                   iter_valid
);

   logistic_map_pkg::fxp_t x_q;
   logic                   issue_valid_q;
   logic                   iter_valid_q;
   logic [1:0]             pend_q;       // items inside the two stages
   logic                   live_q;       // newest item in the stages still counts
   logic                   issue_fire;
   logic                   res_fire;
   logic                   res_keep;

   assign issue_fire = issue_valid_q & issue_ready;
   assign res_fire   = res_valid & res_ready;
   // results return in order, so a kept result is the only one in the pipe
   assign res_keep   = res_fire & live_q & (pend_q == 2'd1) & ~load;

   always_ff @(posedge clk) begin
      if (rst) begin
         x_q           <= `LM_SEED;
         issue_valid_q <= 1'b1;  // first issue right after reset
         iter_valid_q  <= 1'b0;
         pend_q        <= 2'd0;
         live_q        <= 1'b0;
      end else begin
         iter_valid_q <= res_keep;   // one cycle pulse with the new x
         pend_q       <= pend_q + {1'b0, issue_fire} - {1'b0, res_fire};
         if (load) begin
            x_q           <= seed;
            issue_valid_q <= 1'b1;
            live_q        <= 1'b0;   // whatever is in flight goes stale
         end else if (res_keep) begin
            x_q           <= res_x;
            issue_valid_q <= 1'b1;   // straight back into the loop
            live_q        <= 1'b0;
         end else if (issue_fire) begin
            issue_valid_q <= 1'b0;
            live_q        <= 1'b1;
         end
      end
   end

   assign issue_valid = issue_valid_q;
   assign issue_x     = x_q;
   assign res_ready   = 1'b1;        // results are always taken
   assign x           = x_q;
   assign iter_valid  = iter_valid_q;

   // the two stages hold at most two items and return none unasked
   assert property (@(posedge clk) disable iff (rst)
      pend_q != 2'd3);

endmodule

// ==== logic/product_stage.sv ====
`timescale 1ns/100ps
`include "logistic_map_cfg.svh"

// first half of the map, x * (1 - x)
module product_stage (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   in_valid,
   input  logistic_map_pkg::fxp_t in_x,
   input  logic                   out_ready,
   output logic                   in_ready,
   output logic                   out_valid,
   output logistic_map_pkg::fxp_t out_x
);

   logistic_map_pkg::fxp_t one_minus_x;
   logic [63:0]            prod_full;    // Q2.62
   logistic_map_pkg::fxp_t out_x_q;
   logic                   out_valid_q;
   logic                   in_fire;

   assign one_minus_x = `LM_ONE - in_x;
   assign prod_full   = {32'd0, in_x} * {32'd0, one_minus_x};

   // accept when empty or being drained this cycle
   assign in_ready = ~out_valid_q | out_ready;
   assign in_fire  = in_valid & in_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid_q <= 1'b0;
      end else if (in_fire) begin
         out_valid_q <= 1'b1;
      end else if (out_ready) begin
         out_valid_q <= 1'b0;
      end
   end

   // back to Q1.31, truncated; peak is 0.25 so the top bits are zero
   always_ff @(posedge clk) begin
      if (in_fire) out_x_q <= prod_full[`LM_FRAC_BITS +: 32];
   end

   assign out_valid = out_valid_q;
   assign out_x     = out_x_q;

   // x out of range would wrap 1 - x
   assert property (@(posedge clk) disable iff (rst)
      in_fire |-> (in_x <= `LM_ONE));

endmodule

// ==== logic/scale_stage.sv ====
`timescale 1ns/100ps
`include "logistic_map_cfg.svh"

// second half of the map, r * product
module scale_stage (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   in_valid,
   input  logistic_map_pkg::fxp_t in_x,
   input  logic                   out_ready,
   output logic                   in_ready,
   output logic                   out_valid,
   output logistic_map_pkg::fxp_t out_x
);

   logic [63:0]            prod_full;    // Q3.61
   logistic_map_pkg::fxp_t out_x_q;
   logic                   out_valid_q;
   logic                   in_fire;

   assign prod_full = {32'd0, in_x} * {32'd0, `LM_R_CODE};
   assign in_ready  = ~out_valid_q | out_ready;
   assign in_fire   = in_valid & in_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid_q <= 1'b0;
      end else if (in_fire) begin
         out_valid_q <= 1'b1;
      end else if (out_ready) begin
         out_valid_q <= 1'b0;
      end
   end

   // r < 4 keeps the result below 1.0
   always_ff @(posedge clk) begin
      if (in_fire) out_x_q <= prod_full[`LM_R_FRAC +: 32];
   end

   assign out_valid = out_valid_q;
   assign out_x     = out_x_q;

   // a product above 0.25 would push r * p past 1.0
   assert property (@(posedge clk) disable iff (rst)
      in_fire |-> (in_x <= (`LM_ONE >> 2)));

endmodule

// ==== logic/duty_slewer.sv ====
`timescale 1ns/100ps
`include "logistic_map_cfg.svh"

// turns the jumpy iterate into a slowly moving duty
module duty_slewer (
   input  logic                    clk,
   input  logic                    rst,
   input  logistic_map_pkg::fxp_t  x,
   output logistic_map_pkg::duty_t duty
);

   localparam int CNT_W = $clog2(`LM_UPDATE_PERIOD);

   logic [CNT_W-1:0]        cnt_q;      // cycles since last sample
   logistic_map_pkg::duty_t target_q;
   logistic_map_pkg::duty_t duty_q;

   //////////////////////////////////////////////////
   // target sampling
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         cnt_q    <= '0;
         target_q <= '0;
      end else begin
         if (cnt_q == CNT_W'(`LM_UPDATE_PERIOD - 1)) cnt_q <= '0;
         else cnt_q <= cnt_q + 1'b1;
         if (cnt_q == '0) target_q <= x[`LM_DUTY_SHIFT +: `LM_DUTY_BITS];
      end
   end

   //////////////////////////////////////////////////
   // slew, one step per cycle
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         duty_q <= '0;
      end else if (duty_q < target_q) begin
         duty_q <= duty_q + 1'b1;
      end else if (duty_q > target_q) begin
         duty_q <= duty_q - 1'b1;
      end
   end

   assign duty = duty_q;

   assert property (@(posedge clk) disable iff (rst)
      (duty_q == $past(duty_q)) || (duty_q == $past(duty_q) + 1'b1) ||
      (duty_q == $past(duty_q) - 1'b1));

endmodule

// ==== logic/pwm_gen.sv ====
`timescale 1ns/100ps
`include "logistic_map_cfg.svh"

// single pwm channel for the led
module pwm_gen (
   input  logic                    clk,
   input  logic                    rst,
   input  logistic_map_pkg::duty_t duty,
   output logic                    led
);

   logic [`LM_DUTY_BITS-1:0] phase_q;   // free running, wraps

   always_ff @(posedge clk) begin
      if (rst) begin
         phase_q <= '0;
      end else begin
         phase_q <= phase_q + 1'b1;
      end
   end

   // high for duty out of every 2^LM_DUTY_BITS cycles
   assign led = (phase_q < duty);

endmodule

// ==== logic/logistic_map_top.sv ====
`timescale 1ns/100ps

// logistic map loop driving one pwm led
module logistic_map_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    load,
   input  logistic_map_pkg::fxp_t  seed,
   output logistic_map_pkg::fxp_t  x,
   output logic                    iter_valid,
   output logistic_map_pkg::duty_t duty,
   output logic                    led
);

   logic                   issue_valid, issue_ready;
   logistic_map_pkg::fxp_t issue_x;
   logic                   prod_valid, prod_ready;
   logistic_map_pkg::fxp_t prod_x;      // x * (1 - x)
   logic                   res_valid, res_ready;
   logistic_map_pkg::fxp_t res_x;       // next iterate

   iterate_sequencer u_seq (
      .clk(clk), .rst(rst),
      .load(load), .seed(seed),
      .res_valid(res_valid), .res_x(res_x), .res_ready(res_ready),
      .issue_valid(issue_valid), .issue_x(issue_x), .issue_ready(issue_ready),
      .x(x), .iter_valid(iter_valid)
   );

   product_stage u_prod (
      .clk(clk), .rst(rst),
      .in_valid(issue_valid), .in_x(issue_x), .in_ready(issue_ready),
      .out_valid(prod_valid), .out_x(prod_x), .out_ready(prod_ready)
   );

   scale_stage u_scale (
      .clk(clk), .rst(rst),
      .in_valid(prod_valid), .in_x(prod_x), .in_ready(prod_ready),
      .out_valid(res_valid), .out_x(res_x), .out_ready(res_ready)
   );

   duty_slewer u_slew (
      .clk(clk), .rst(rst),
      .x(x),
      .duty(duty)
   );

   pwm_gen u_pwm (
      .clk(clk), .rst(rst),
      .duty(duty),
      .led(led)
   );

endmodule

// ==== sim/tb_logistic_map.sv ====
`timescale 1ns/100ps
`include "logistic_map_cfg.svh"

// directed tests for the logistic map loop and its led output
module tb_logistic_map;

   localparam int CLK_PERIOD  = 20;
   localparam int ITER_LIMIT  = 12;                        // cycles allowed per iterate
   localparam int CHAIN_LEN   = 30;
   localparam int LOAD_COUNT  = 8;
   localparam int SETTLE_MAX  = 2 * `LM_UPDATE_PERIOD + 256;
   localparam int HOLD_CYCLES = 2 * `LM_UPDATE_PERIOD;
   // reset, first iterate, chain, three iterates per load, duty settle and hold
   localparam int TEST_CYCLES = 2 + ITER_LIMIT + 3 * CHAIN_LEN + LOAD_COUNT * 3 * ITER_LIMIT
                                + SETTLE_MAX + HOLD_CYCLES;

   logic                     clk = 1'b0;
   logic                     rst;
   logic                     load;
   logistic_map_pkg::fxp_t   seed;
   logistic_map_pkg::fxp_t   x;
   logic                     iter_valid;
   logistic_map_pkg::duty_t  duty;
   logic                     led;

   logic [31:0]              rng;           // xorshift state
   logistic_map_pkg::fxp_t   expect_x;      // model chain
   logic [`LM_DUTY_BITS-1:0] phase;         // mirror of the pwm counter
   logistic_map_pkg::duty_t  duty_prev;
   logic                     duty_prev_ok;

   logistic_map_top dut (
      .clk(clk), .rst(rst),
      .load(load), .seed(seed),
      .x(x), .iter_valid(iter_valid),
      .duty(duty), .led(led)
   );

   initial begin
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // whole run bounded at twice the expected length
   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      $display("timeout, tests still running after %0d cycles", 2 * TEST_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
   end

   //////////////////////////////////////////////////
   // model and helpers
   //////////////////////////////////////////////////

   // x <- r * x * (1 - x), q1.31 iterate, q2.30 r, truncating shifts
   function automatic logistic_map_pkg::fxp_t next_iterate(input logistic_map_pkg::fxp_t xi);
      logic [63:0] a;
      logic [63:0] p;
      logic [63:0] s;
      a = 64'(xi);
      p = (a * (64'(`LM_ONE) - a)) >> `LM_FRAC_BITS;
      s = (p * 64'(`LM_R_CODE)) >> `LM_R_FRAC;
      return s[31:0];
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] state);
      logic [31:0] v;
      v = state;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   task automatic compare_value(input string name, input logic [63:0] got,
                                input logic [63:0] expected);
      if (got !== expected) begin
         $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, expected);
         $display("ERRORS FOUND");
         $fatal(1, "value mismatch");
      end
   endtask

   // next iter_valid pulse, sampled on the falling edge
   task automatic wait_for_iterate(output logistic_map_pkg::fxp_t value, output int waited);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!iter_valid && n < ITER_LIMIT);
      if (!iter_valid) begin
         $display("no iter_valid pulse within %0d cycles", ITER_LIMIT);
         $display("ERRORS FOUND");
         $fatal(1, "iterate timeout");
      end
      value  = x;
      waited = n;
   endtask

   // per cycle: reset values, duty slew limit, led against mirrored phase
   always @(negedge clk) begin : cycle_monitor
      logistic_map_pkg::duty_t diff;
      if (rst) begin
         compare_value("iter_valid", 64'(iter_valid), 64'd0);
         compare_value("duty", 64'(duty), 64'd0);
         compare_value("led", 64'(led), 64'd0);
         phase        = '0;
         duty_prev_ok = 1'b0;
      end else begin
         compare_value("led", 64'(led), 64'(phase < duty));
         diff = (duty > duty_prev) ? duty - duty_prev : duty_prev - duty;
         if (duty_prev_ok) compare_value("duty step above one", 64'(diff > 8'd1), 64'd0);
         duty_prev    = duty;
         duty_prev_ok = 1'b1;
         phase        = phase + 1'b1;      // wraps like the dut counter
      end
   end

   //////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////

   task automatic reset_and_first_iterate();
      logistic_map_pkg::fxp_t value;
      int waited;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);                       // first cycle out of reset
      compare_value("iter_valid", 64'(iter_valid), 64'd0);
      compare_value("duty", 64'(duty), 64'd0);
      compare_value("led", 64'(led), 64'd0);
      wait_for_iterate(value, waited);
      expect_x = next_iterate(`LM_SEED);
      compare_value("x", 64'(value), 64'(expect_x));
      compare_value("first iter_valid delay", 64'(waited), 64'd3);  // issue, product, scale
   endtask

   task automatic run_chain();
      logistic_map_pkg::fxp_t value;
      int waited;
      repeat (CHAIN_LEN) begin
         wait_for_iterate(value, waited);
         expect_x = next_iterate(expect_x);
         compare_value("x", 64'(value), 64'(expect_x));
         compare_value("iter_valid spacing", 64'(waited), 64'd3);
      end
      // first target came from the 0.5 seed so duty has been climbing
      compare_value("duty moving", 64'(duty != '0), 64'd1);
   endtask

   // load lands one or two cycles after an issue, item always in flight
   task automatic load_random_seeds();
      logistic_map_pkg::fxp_t value;
      logistic_map_pkg::fxp_t s;
      int waited;
      for (int i = 0; i < LOAD_COUNT; i++) begin
         rng = xorshift(rng);
         s   = rng & (`LM_ONE - 32'd1);     // below 1.0
         wait_for_iterate(value, waited);   // sync to the loop
         expect_x = next_iterate(expect_x);
         compare_value("x", 64'(value), 64'(expect_x));
         repeat (1 + i % 2) @(posedge clk);
         load <= 1'b1;
         seed <= s;
         @(posedge clk);
         load <= 1'b0;
         // stale result dropped, first pulse carries f(seed)
         wait_for_iterate(value, waited);
         expect_x = next_iterate(s);
         compare_value("x after load", 64'(value), 64'(expect_x));
         compare_value("load to iter_valid", 64'(waited), 64'd4);
         wait_for_iterate(value, waited);
         expect_x = next_iterate(expect_x);
         compare_value("x", 64'(value), 64'(expect_x));
      end
   endtask

   // seed 0 is a fixed point, so duty must slew down to 0 and stay
   task automatic settle_duty();
      int n;
      @(posedge clk);
      load <= 1'b1;
      seed <= '0;
      @(posedge clk);
      load <= 1'b0;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (duty != '0 && n < SETTLE_MAX);
      if (duty != '0) begin
         $display("duty did not reach zero within %0d cycles of loading seed 0", SETTLE_MAX);
         $display("ERRORS FOUND");
         $fatal(1, "duty settle timeout");
      end
      repeat (HOLD_CYCLES) begin
         @(negedge clk);
         compare_value("duty", 64'(duty), 64'd0);
         compare_value("x", 64'(x), 64'd0);
      end
   endtask

   initial begin
      rst          = 1'b1;
      load         = 1'b0;
      seed         = '0;
      rng          = 32'h9678_4bda;
      expect_x     = '0;
      phase        = '0;
      duty_prev    = '0;
      duty_prev_ok = 1'b0;
      reset_and_first_iterate();
      run_chain();
      load_random_seeds();
      settle_duty();
      $display("NO ERRORS");
      $finish;
   end

endmodule

// ==== logistic_map_top.f ====
+incdir+logic
logic/logistic_map_pkg.sv
logic/iterate_sequencer.sv
logic/product_stage.sv
logic/scale_stage.sv
logic/duty_slewer.sv
logic/pwm_gen.sv
logic/logistic_map_top.sv
sim/tb_logistic_map.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = tb_logistic_map
FILELIST   = logistic_map_top.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
